// File: soc_ctrl_pkg.sv
// ====================
// SoC control package
// Widths, register offsets and bus structs shared by the
// APB SoC control block, its register file and counters
// ====================
package soc_ctrl_pkg;

   // Base widths
   localparam int unsigned ADDR_W          = 32;
   localparam int unsigned DATA_W          = 32;
   localparam int unsigned KEY_W           = 128;
   localparam int unsigned CLK_SEL_W       = 2;

   // Logic-locking key storage, four words per key
   localparam int unsigned NUM_KEYS        = 4;
   localparam int unsigned KEY_WORDS       = 4;
   localparam int unsigned KEY_WORDS_TOTAL = NUM_KEYS * KEY_WORDS;

   localparam int unsigned NUM_LLC_EVENTS  = 4;

   typedef logic [ADDR_W-1:0]                   paddr_t;
   typedef logic [DATA_W-1:0]                   word_t;
   typedef logic [KEY_W-1:0]                    key_t;
   typedef logic [CLK_SEL_W-1:0]                clk_sel_t;
   typedef logic [$clog2(KEY_WORDS_TOTAL)-1:0]  key_idx_t;

   // Register map, byte offsets of 32-bit words
   localparam paddr_t ADDR_CLUSTER_CTRL    = 32'h00;
   localparam paddr_t ADDR_LLC_CACHE_START = 32'h04;
   localparam paddr_t ADDR_LLC_CACHE_END   = 32'h08;
   localparam paddr_t ADDR_LLC_SPM_START   = 32'h0C;
   localparam paddr_t ADDR_LLC_CNT_EN      = 32'h10;
   localparam paddr_t ADDR_LLC_RD_HIT      = 32'h14;
   localparam paddr_t ADDR_LLC_RD_MISS     = 32'h18;
   localparam paddr_t ADDR_LLC_WR_HIT      = 32'h1C;
   localparam paddr_t ADDR_LLC_WR_MISS     = 32'h20;
   localparam paddr_t ADDR_OT_CLK_SEL      = 32'h24;
   localparam paddr_t ADDR_OT_CLK_DIV      = 32'h28;
   localparam paddr_t ADDR_OT_CLK_GATE     = 32'h2C;
   localparam paddr_t ADDR_KEY_BASE        = 32'h30;
   // Everything from here up is unmapped
   localparam paddr_t ADDR_MAP_END         = 32'h70;

   typedef struct packed {
      logic   valid;
      logic   write;
      paddr_t addr;
      word_t  wdata;
   } reg_req_t;

   typedef struct packed {
      word_t  rdata;
      logic   error;
      logic   ready;
   } reg_rsp_t;

   // Listed MSB first so that reset_n lands on bit 0 of the register
   typedef struct packed {
      logic fetch_en;
      logic en_sa_boot;
      logic reset_n;
   } cluster_ctrl_t;

   typedef struct packed {
      logic read_hit;
      logic read_miss;
      logic write_hit;
      logic write_miss;
   } llc_events_t;

   typedef struct packed {
      word_t read_hit;
      word_t read_miss;
      word_t write_hit;
      word_t write_miss;
   } llc_counts_t;

endpackage

// File: apb_to_reg.sv
`timescale 1ns/100ps
// ====================
// APB to register bus bridge
// Turns the APB access phase into a one-cycle register request,
// returns the response on the APB signals and rejects access
// phases that were not preceded by a setup cycle
// ====================
module apb_to_reg (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic                   psel_i,
   input  logic                   penable_i,
   input  logic                   pwrite_i,
   input  soc_ctrl_pkg::paddr_t   paddr_i,
   input  soc_ctrl_pkg::word_t    pwdata_i,
   output soc_ctrl_pkg::word_t    prdata_o,
   output logic                   pready_o,
   output logic                   pslverr_o,
   output soc_ctrl_pkg::reg_req_t reg_req_o,
   input  soc_ctrl_pkg::reg_rsp_t reg_rsp_i
);
   import soc_ctrl_pkg::*;

   typedef enum logic [1:0] {
      APB_IDLE,
      APB_SETUP,
      APB_ACCESS
   } apb_state_e;

   apb_state_e state_q;
   apb_state_e state_d;
   logic       access_phase;
   logic       proto_err;
   logic       req_valid;

   assign access_phase = psel_i & penable_i;

   // An access phase is only legal right after a setup cycle
   assign proto_err = access_phase & (state_q != APB_SETUP);
   assign req_valid = access_phase & ~proto_err;

   always_comb begin
      state_d = APB_IDLE;
      if (psel_i && !penable_i) begin
         state_d = APB_SETUP;
      end else if (access_phase) begin
         state_d = APB_ACCESS;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= APB_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Register file only sees word-aligned addresses
   always_comb begin
      reg_req_o.valid = req_valid;
      reg_req_o.write = pwrite_i;
      reg_req_o.addr  = {paddr_i[ADDR_W-1:2], 2'b00};
      reg_req_o.wdata = pwdata_i;
   end

   assign prdata_o  = (req_valid && !pwrite_i) ? reg_rsp_i.rdata : '0;
   assign pready_o  = reg_rsp_i.ready;
   assign pslverr_o = reg_rsp_i.error | proto_err;

endmodule

// File: soc_ctrl_regs.sv
`timescale 1ns/100ps
// ====================
// SoC control register file
// Address decode, software-writable control fields, key storage
// with pairwise XOR, and the read mux that also shows the LLC
// performance counters
// ====================
module soc_ctrl_regs (
   input  logic                        clk_i,
   input  logic                        rst_n_i,
   input  soc_ctrl_pkg::reg_req_t      reg_req_i,
   output soc_ctrl_pkg::reg_rsp_t      reg_rsp_o,
   input  soc_ctrl_pkg::llc_counts_t   llc_counts_i,
   output soc_ctrl_pkg::cluster_ctrl_t cluster_ctrl_o,
   output soc_ctrl_pkg::word_t         llc_cache_addr_start_o,
   output soc_ctrl_pkg::word_t         llc_cache_addr_end_o,
   output soc_ctrl_pkg::word_t         llc_spm_addr_start_o,
   output logic                        llc_cnt_en_o,
   output soc_ctrl_pkg::clk_sel_t      ot_clk_sel_o,
   output soc_ctrl_pkg::word_t         ot_clk_div_o,
   output logic                        ot_clk_div_qe_o,
   output logic                        ot_clk_gate_en_o,
   output soc_ctrl_pkg::key_t          xor_locking_blk_0_o,
   output soc_ctrl_pkg::key_t          xor_locking_blk_1_o
);
   import soc_ctrl_pkg::*;

   cluster_ctrl_t cluster_ctrl_q;
   word_t         llc_cache_start_q;
   word_t         llc_cache_end_q;
   word_t         llc_spm_start_q;
   logic          llc_cnt_en_q;
   clk_sel_t      ot_clk_sel_q;
   word_t         ot_clk_div_q;
   logic          ot_clk_div_qe_q;
   logic          ot_clk_gate_en_q;
   word_t         key_word_q [KEY_WORDS_TOTAL];
   key_t          key_val [NUM_KEYS];

   logic          addr_mapped;
   logic          addr_is_key;
   logic          wr_en;
   paddr_t        key_off;
   key_idx_t      key_idx;
   word_t         rdata;

   assign addr_mapped = reg_req_i.addr < ADDR_MAP_END;
   assign addr_is_key = addr_mapped && (reg_req_i.addr >= ADDR_KEY_BASE);

   // Key words are laid out back to back, four per key
   assign key_off = reg_req_i.addr - ADDR_KEY_BASE;
   assign key_idx = key_off[$bits(key_idx_t)+1:2];

   assign wr_en = reg_req_i.valid & reg_req_i.write & addr_mapped;

   // Control fields, each keeping only its own width of the write data
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cluster_ctrl_q    <= '0;
         llc_cache_start_q <= '0;
         llc_cache_end_q   <= '0;
         llc_spm_start_q   <= '0;
         llc_cnt_en_q      <= 1'b0;
         ot_clk_sel_q      <= '0;
         ot_clk_div_q      <= '0;
         ot_clk_div_qe_q   <= 1'b0;
         ot_clk_gate_en_q  <= 1'b0;
      end else begin
         // Pulse lines up with the first cycle of the new divider value
         ot_clk_div_qe_q <= wr_en && (reg_req_i.addr == ADDR_OT_CLK_DIV);
         if (wr_en) begin
            case (reg_req_i.addr)
               ADDR_CLUSTER_CTRL: begin
                  cluster_ctrl_q <= reg_req_i.wdata[$bits(cluster_ctrl_t)-1:0];
               end
               ADDR_LLC_CACHE_START: llc_cache_start_q <= reg_req_i.wdata;
               ADDR_LLC_CACHE_END:   llc_cache_end_q   <= reg_req_i.wdata;
               ADDR_LLC_SPM_START:   llc_spm_start_q   <= reg_req_i.wdata;
               ADDR_LLC_CNT_EN:      llc_cnt_en_q      <= reg_req_i.wdata[0];
               ADDR_OT_CLK_SEL:      ot_clk_sel_q      <= reg_req_i.wdata[CLK_SEL_W-1:0];
               ADDR_OT_CLK_DIV:      ot_clk_div_q      <= reg_req_i.wdata;
               ADDR_OT_CLK_GATE:     ot_clk_gate_en_q  <= reg_req_i.wdata[0];
               // Counter addresses are read-only and keys are handled below
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < KEY_WORDS_TOTAL; i++) begin
            key_word_q[i] <= '0;
         end
      end else if (wr_en && addr_is_key) begin
         key_word_q[key_idx] <= reg_req_i.wdata;
      end
   end

   // Word w of a key holds bits 32w+31 down to 32w
   always_comb begin
      for (int k = 0; k < NUM_KEYS; k++) begin
         for (int w = 0; w < KEY_WORDS; w++) begin
            key_val[k][w*DATA_W +: DATA_W] = key_word_q[k*KEY_WORDS + w];
         end
      end
   end

   assign xor_locking_blk_0_o = key_val[0] ^ key_val[1];
   assign xor_locking_blk_1_o = key_val[2] ^ key_val[3];

   // Read mux, narrow fields come back zero-extended
   always_comb begin
      rdata = '0;
      case (reg_req_i.addr)
         ADDR_CLUSTER_CTRL:    rdata[$bits(cluster_ctrl_t)-1:0] = cluster_ctrl_q;
         ADDR_LLC_CACHE_START: rdata = llc_cache_start_q;
         ADDR_LLC_CACHE_END:   rdata = llc_cache_end_q;
         ADDR_LLC_SPM_START:   rdata = llc_spm_start_q;
         ADDR_LLC_CNT_EN:      rdata[0] = llc_cnt_en_q;
         ADDR_LLC_RD_HIT:      rdata = llc_counts_i.read_hit;
         ADDR_LLC_RD_MISS:     rdata = llc_counts_i.read_miss;
         ADDR_LLC_WR_HIT:      rdata = llc_counts_i.write_hit;
         ADDR_LLC_WR_MISS:     rdata = llc_counts_i.write_miss;
         ADDR_OT_CLK_SEL:      rdata[CLK_SEL_W-1:0] = ot_clk_sel_q;
         ADDR_OT_CLK_DIV:      rdata = ot_clk_div_q;
         ADDR_OT_CLK_GATE:     rdata[0] = ot_clk_gate_en_q;
         default: begin
            if (addr_is_key) begin
               rdata = key_word_q[key_idx];
            end
         end
      endcase
   end

   // Zero-wait slave, error only for accesses outside the map
   always_comb begin
      reg_rsp_o.rdata = rdata;
      reg_rsp_o.error = reg_req_i.valid & ~addr_mapped;
      reg_rsp_o.ready = 1'b1;
   end

   assign cluster_ctrl_o         = cluster_ctrl_q;
   assign llc_cache_addr_start_o = llc_cache_start_q;
   assign llc_cache_addr_end_o   = llc_cache_end_q;
   assign llc_spm_addr_start_o   = llc_spm_start_q;
   assign llc_cnt_en_o           = llc_cnt_en_q;
   assign ot_clk_sel_o           = ot_clk_sel_q;
   assign ot_clk_div_o           = ot_clk_div_q;
   assign ot_clk_div_qe_o        = ot_clk_div_qe_q;
   assign ot_clk_gate_en_o       = ot_clk_gate_en_q;

endmodule

// File: llc_perf_counters.sv
`timescale 1ns/100ps
// ====================
// LLC performance counters
// Four free-running 32-bit counters for LLC read/write hits and
// misses, advancing only while software enables them
// ====================
module llc_perf_counters (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  logic                      enable_i,
   input  soc_ctrl_pkg::llc_events_t events_i,
   output soc_ctrl_pkg::llc_counts_t counts_o
);
   import soc_ctrl_pkg::*;

   logic [NUM_LLC_EVENTS-1:0] event_vec;
   word_t                     cnt_q [NUM_LLC_EVENTS];

   // Events and counts share one field order, so event bit i feeds
   // counter word i
   assign event_vec = events_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < NUM_LLC_EVENTS; i++) begin
            cnt_q[i] <= '0;
         end
      end else begin
         for (int i = 0; i < NUM_LLC_EVENTS; i++) begin
            // Plain 32-bit add, so the count wraps on overflow
            if (enable_i && event_vec[i]) begin
               cnt_q[i] <= cnt_q[i] + 1'b1;
            end
         end
      end
   end

   always_comb begin
      for (int i = 0; i < NUM_LLC_EVENTS; i++) begin
         counts_o[i*DATA_W +: DATA_W] = cnt_q[i];
      end
   end

endmodule

// File: apb_soc_control.sv
`timescale 1ns/100ps
// ====================
// APB SoC control block
// Cluster boot controls, LLC windows and counters, second clock
// domain controls and logic-locking keys behind an APB slave
// ====================
module apb_soc_control (
   input  logic                        clk_i,
   input  logic                        rst_n_i,

   // APB slave
   input  logic                        psel_i,
   input  logic                        penable_i,
   input  logic                        pwrite_i,
   input  soc_ctrl_pkg::paddr_t        paddr_i,
   input  soc_ctrl_pkg::word_t         pwdata_i,
   output soc_ctrl_pkg::word_t         prdata_o,
   output logic                        pready_o,
   output logic                        pslverr_o,

   output soc_ctrl_pkg::cluster_ctrl_t cluster_ctrl_o,
   output soc_ctrl_pkg::word_t         llc_cache_addr_start_o,
   output soc_ctrl_pkg::word_t         llc_cache_addr_end_o,
   output soc_ctrl_pkg::word_t         llc_spm_addr_start_o,
   input  soc_ctrl_pkg::llc_events_t   llc_events_i,

   output soc_ctrl_pkg::clk_sel_t      ot_clk_sel_o,
   output soc_ctrl_pkg::word_t         ot_clk_div_o,
   output logic                        ot_clk_div_qe_o,
   output logic                        ot_clk_gate_en_o,

   output soc_ctrl_pkg::key_t          xor_locking_blk_0_o,
   output soc_ctrl_pkg::key_t          xor_locking_blk_1_o
);
   import soc_ctrl_pkg::*;

   reg_req_t    reg_req;
   reg_rsp_t    reg_rsp;
   llc_counts_t llc_counts;
   logic        llc_cnt_en;

   apb_to_reg i_apb_to_reg (
      .clk_i     ( clk_i     ),
      .rst_n_i   ( rst_n_i   ),
      .psel_i    ( psel_i    ),
      .penable_i ( penable_i ),
      .pwrite_i  ( pwrite_i  ),
      .paddr_i   ( paddr_i   ),
      .pwdata_i  ( pwdata_i  ),
      .prdata_o  ( prdata_o  ),
      .pready_o  ( pready_o  ),
      .pslverr_o ( pslverr_o ),
      .reg_req_o ( reg_req   ),
      .reg_rsp_i ( reg_rsp   )
   );

   soc_ctrl_regs i_soc_ctrl_regs (
      .clk_i                  ( clk_i                  ),
      .rst_n_i                ( rst_n_i                ),
      .reg_req_i              ( reg_req                ),
      .reg_rsp_o              ( reg_rsp                ),
      .llc_counts_i           ( llc_counts             ),
      .cluster_ctrl_o         ( cluster_ctrl_o         ),
      .llc_cache_addr_start_o ( llc_cache_addr_start_o ),
      .llc_cache_addr_end_o   ( llc_cache_addr_end_o   ),
      .llc_spm_addr_start_o   ( llc_spm_addr_start_o   ),
      .llc_cnt_en_o           ( llc_cnt_en             ),
      .ot_clk_sel_o           ( ot_clk_sel_o           ),
      .ot_clk_div_o           ( ot_clk_div_o           ),
      .ot_clk_div_qe_o        ( ot_clk_div_qe_o        ),
      .ot_clk_gate_en_o       ( ot_clk_gate_en_o       ),
      .xor_locking_blk_0_o    ( xor_locking_blk_0_o    ),
      .xor_locking_blk_1_o    ( xor_locking_blk_1_o    )
   );

   // Counter values come back to the register file for reads
   llc_perf_counters i_llc_perf_counters (
      .clk_i    ( clk_i        ),
      .rst_n_i  ( rst_n_i      ),
      .enable_i ( llc_cnt_en   ),
      .events_i ( llc_events_i ),
      .counts_o ( llc_counts   )
   );

endmodule

// File: apb_soc_control_props.sv
`timescale 1ns/100ps
// ====================
// APB SoC control properties
// Bus response rules and control output rules of the top level
// ====================
module apb_soc_control_props (
   input logic                        clk_i,
   input logic                        rst_n_i,
   input logic                        psel_i,
   input logic                        penable_i,
   input logic                        pwrite_i,
   input soc_ctrl_pkg::paddr_t        paddr_i,
   input logic                        pready_o,
   input logic                        pslverr_o,
   input logic                        ot_clk_div_qe_o,
   input soc_ctrl_pkg::cluster_ctrl_t cluster_ctrl_o
);
   import soc_ctrl_pkg::*;

   logic access_phase;
   logic ctrl_write;

   assign access_phase = psel_i & penable_i;
   assign ctrl_write   = access_phase & pwrite_i &
                         ({paddr_i[31:2], 2'b00} == ADDR_CLUSTER_CTRL);

   // Zero-wait slave
   pready_in_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      access_phase |-> pready_o)
      else $error("pready low during an APB access phase");

   qe_single_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ot_clk_div_qe_o |=> !ot_clk_div_qe_o)
      else $error("divider update pulse lasted two cycles");

   pslverr_in_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !access_phase |-> !pslverr_o)
      else $error("pslverr high outside an APB access phase");

   // The cluster leaves reset only through a control register write
   cluster_held_in_reset: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (!cluster_ctrl_o.reset_n && !ctrl_write) |=> !cluster_ctrl_o.reset_n)
      else $error("cluster reset released without a control write");

endmodule

bind apb_soc_control apb_soc_control_props props_i (.*);

// File: tb_apb_soc_control.sv
`timescale 1ns/100ps
// ====================
// APB SoC control testbench
// Replays the trace of APB accesses, LLC event bursts and output
// checks, with its own model of the counters, enable bit and keys
// ====================
module tb_apb_soc_control;
   import soc_ctrl_pkg::*;

   localparam int TIMEOUT_CYCLES = 20;
   localparam int MAX_LINES      = 400;

   logic          clk_i;
   logic          rst_n_i;
   logic          psel_i;
   logic          penable_i;
   logic          pwrite_i;
   paddr_t        paddr_i;
   word_t         pwdata_i;
   word_t         prdata_o;
   logic          pready_o;
   logic          pslverr_o;
   cluster_ctrl_t cluster_ctrl_o;
   word_t         llc_cache_addr_start_o;
   word_t         llc_cache_addr_end_o;
   word_t         llc_spm_addr_start_o;
   llc_events_t   llc_events_i;
   clk_sel_t      ot_clk_sel_o;
   word_t         ot_clk_div_o;
   logic          ot_clk_div_qe_o;
   logic          ot_clk_gate_en_o;
   key_t          xor_locking_blk_0_o;
   key_t          xor_locking_blk_1_o;

   int            n_checks = 0;
   int            n_errors = 0;
   int            qe_count = 0;
   integer        seed     = 32'hd00364e9;
   logic          model_en;
   word_t         model_cnt [4];
   word_t         model_key [KEY_WORDS_TOTAL];

   apb_soc_control dut_i (.*);

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   initial begin
      rst_n_i = 1'b0;
      repeat (10) @(posedge clk_i);
      rst_n_i <= 1'b1;
   end

   // Each divider pulse is counted at the edge that ends it
   always @(posedge clk_i) begin
      if (ot_clk_div_qe_o) begin
         qe_count = qe_count + 1;
      end
   end

   task automatic check_value(input string name, input key_t expected, input key_t actual);
      n_checks++;
      assert (actual === expected) else begin
         n_errors++;
         $display("ERR %s: expected %0h, actual %0h", name, expected, actual);
      end
   endtask

   task automatic abort_run(input string why);
      n_errors++;
      $display("%s", why);
      $display("Checks: %0d, errors: %0d", n_checks, n_errors);
      $display("Test failed");
      $finish;
   endtask

   function automatic word_t hex_value(input string s);
      word_t v;
      int    n;
      v = '0;
      n = $sscanf(s, "%h", v);
      return v;
   endfunction

   // Word w of key k holds key bits 32w+31 down to 32w
   function automatic key_t key_model(input int k);
      key_t v;
      for (int w = 0; w < KEY_WORDS; w++) begin
         v[w*32 +: 32] = model_key[k*KEY_WORDS + w];
      end
      return v;
   endfunction

   task automatic apb_xfer(input logic wr, input paddr_t addr, input word_t wdata,
                           output word_t rdata, output logic err);
      int waited;
      @(posedge clk_i);
      psel_i    <= 1'b1;
      penable_i <= 1'b0;
      pwrite_i  <= wr;
      paddr_i   <= addr;
      pwdata_i  <= wdata;
      @(posedge clk_i);
      penable_i <= 1'b1;
      @(negedge clk_i);
      waited = 0;
      while (!pready_o && waited < TIMEOUT_CYCLES) begin
         @(negedge clk_i);
         waited++;
      end
      if (!pready_o) abort_run("pready stayed low in the APB access phase");
      rdata = prdata_o;
      err   = pslverr_o;
      @(posedge clk_i);
      psel_i    <= 1'b0;
      penable_i <= 1'b0;
   endtask

   task automatic drive_events(input logic rand_mode, input logic [3:0] pattern,
                               input int cycles);
      word_t       r;
      llc_events_t ev;
      for (int i = 0; i < cycles; i++) begin
         @(posedge clk_i);
         ev = pattern;
         if (rand_mode) begin
            r  = $random(seed);
            ev = r[3:0];
         end
         llc_events_i <= ev;
         // The pattern is sampled at the next edge, counted only while enabled
         if (model_en) begin
            model_cnt[0] = model_cnt[0] + ev.read_hit;
            model_cnt[1] = model_cnt[1] + ev.read_miss;
            model_cnt[2] = model_cnt[2] + ev.write_hit;
            model_cnt[3] = model_cnt[3] + ev.write_miss;
         end
      end
      @(posedge clk_i);
      llc_events_i <= '0;
   endtask

   task automatic run_op(input string op, input string sel, input string dat, input string xp);
      paddr_t addr;
      word_t  data;
      word_t  rdata;
      word_t  expv;
      word_t  off;
      logic   err;
      key_t   act;
      key_t   expk;
      addr = hex_value(sel);
      case (op)
         "WR": begin
            data = hex_value(dat);
            apb_xfer(1'b1, addr, data, rdata, err);
            check_value($sformatf("WR %h pslverr", addr), {96'b0, hex_value(xp)},
                        {127'b0, err});
            if (addr < ADDR_MAP_END) begin
               off = addr - ADDR_KEY_BASE;
               if (addr == ADDR_LLC_CNT_EN) model_en = data[0];
               if (addr >= ADDR_KEY_BASE) model_key[off[5:2]] = data;
            end
         end
         "RD": begin
            apb_xfer(1'b0, addr, '0, rdata, err);
            check_value($sformatf("RD %h pslverr", addr), {96'b0, hex_value(dat)},
                        {127'b0, err});
            off  = addr - ADDR_LLC_RD_HIT;
            expv = (xp == "MODEL") ? model_cnt[off[3:2]] : hex_value(xp);
            if (hex_value(dat) == '0) begin
               check_value($sformatf("RD %h", addr), {96'b0, expv}, {96'b0, rdata});
            end
         end
         "EV": begin
            data = hex_value(sel);
            drive_events(sel == "R", data[3:0], hex_value(dat));
         end
         "CHK": begin
            // One idle cycle lets the pulse counter catch up
            @(posedge clk_i);
            @(negedge clk_i);
            act  = '0;
            expk = {96'b0, hex_value(xp)};
            case (sel)
               "ANY": act[0] = |{cluster_ctrl_o, llc_cache_addr_start_o, llc_cache_addr_end_o,
                                 llc_spm_addr_start_o, ot_clk_sel_o, ot_clk_div_o,
                                 ot_clk_div_qe_o, ot_clk_gate_en_o,
                                 xor_locking_blk_0_o, xor_locking_blk_1_o};
               "CTRL":  act[2:0]  = cluster_ctrl_o;
               "CEND":  act[31:0] = llc_cache_addr_end_o;
               "CSEL":  act[1:0]  = ot_clk_sel_o;
               "CDIV":  act[31:0] = ot_clk_div_o;
               "QECNT": act[31:0] = qe_count;
               "XOR0": begin
                  act  = xor_locking_blk_0_o;
                  expk = key_model(0) ^ key_model(1);
               end
               "XOR1": begin
                  act  = xor_locking_blk_1_o;
                  expk = key_model(2) ^ key_model(3);
               end
               default: abort_run({"unknown output selector in the trace: ", sel});
            endcase
            check_value({"CHK ", sel}, expk, act);
         end
         default: abort_run({"unknown operation in the trace: ", op});
      endcase
   endtask

   initial begin
      string              op;
      string              sel;
      string              dat;
      string              xp;
      logic [8*256-1:0]   rest;
      int                 fd;
      int                 n;
      int                 lines;
      int                 waited;
      psel_i       = 1'b0;
      penable_i    = 1'b0;
      pwrite_i     = 1'b0;
      paddr_i      = '0;
      pwdata_i     = '0;
      llc_events_i = '0;
      model_en     = 1'b0;
      for (int i = 0; i < 4; i++) model_cnt[i] = '0;
      for (int i = 0; i < KEY_WORDS_TOTAL; i++) model_key[i] = '0;
      fd = $fopen("apb_soc_control_trace.txt", "r");
      if (fd == 0) abort_run("cannot open apb_soc_control_trace.txt");
      waited = 0;
      while (!rst_n_i && waited < TIMEOUT_CYCLES) begin
         @(posedge clk_i);
         waited++;
      end
      if (!rst_n_i) abort_run("reset was never released");
      lines = 0;
      while (!$feof(fd) && lines < MAX_LINES) begin
         lines++;
         n = $fscanf(fd, "%s", op);
         if (n == 1 && op == "#") begin
            n = $fgets(rest, fd);
         end else if (n == 1) begin
            n = $fscanf(fd, "%s %s %s", sel, dat, xp);
            if (n != 3) abort_run({"incomplete trace line for operation ", op});
            run_op(op, sel, dat, xp);
         end
      end
      if (!$feof(fd)) begin
         abort_run("trace is longer than the line limit");
      end else begin
         $fclose(fd);
         $display("Trace lines: %0d, checks: %0d, errors: %0d", lines, n_checks, n_errors);
         if (n_errors == 0) begin
            $display("Test completed successfully");
         end else begin
            $display("Test failed");
         end
         $finish;
      end
   end

endmodule

// File: apb_soc_control_trace.txt
# op addr/sel data expected; WR: data and pslverr, RD: pslverr and read data or MODEL
# EV: pattern (R for random) and cycles, CHK: output and value or KEY; numbers are hex
CHK ANY 0 0
RD 14 0 0
WR 0 7 0
CHK CTRL 0 7
RD 0 0 7
WR 8 8000ffff 0
CHK CEND 0 8000ffff
WR 24 ffffffff 0
CHK CSEL 0 3
RD 24 0 3
WR 28 1234 0
WR 28 5678 0
CHK CDIV 0 5678
CHK QECNT 0 2
WR 30 01234567 0
WR 34 89abcdef 0
WR 38 deadbeef 0
WR 3c 0badf00d 0
WR 40 fedcba98 0
WR 44 76543210 0
WR 48 a5a5a5a5 0
WR 4c 5a5a5a5a 0
WR 50 13579bdf 0
WR 54 2468ace0 0
WR 58 ffff0000 0
WR 5c 0000ffff 0
WR 60 c0ffee00 0
WR 64 11223344 0
WR 68 55667788 0
WR 6c 99aabbcc 0
CHK XOR0 0 KEY
CHK XOR1 0 KEY
EV f 5 0
RD 20 0 0
WR 10 1 0
EV 8 3 0
EV 5 2 0
EV f 2 0
EV R 20 0
RD 14 0 MODEL
RD 18 0 MODEL
RD 1c 0 MODEL
RD 20 0 MODEL
WR 10 0 0
EV f 4 0
RD 14 0 MODEL
WR 14 ffff 0
RD 14 0 MODEL
WR 70 1 1
RD 7c 1 0
CHK CTRL 0 7
CHK XOR0 0 KEY

// File: apb_soc_control.f
soc_ctrl_pkg.sv
apb_to_reg.sv
soc_ctrl_regs.sv
llc_perf_counters.sv
apb_soc_control.sv
apb_soc_control_props.sv
tb_apb_soc_control.sv
